//--- nice_isa_pkg.sv
`default_nettype none

package nice_isa_pkg;

  //////////////////////////////////////////////////
  // R-type instruction fields
  //////////////////////////////////////////////////

  // Bit positions and widths inside the 32-bit instruction word
  localparam int opcode_lsb = 0;
  localparam int opcode_w   = 7;
  localparam int funct3_lsb = 12;
  localparam int funct3_w   = 3;
  localparam int funct7_lsb = 25;
  localparam int funct7_w   = 7;

  // Only the custom-3 major opcode is decoded here
  localparam logic [opcode_w-1:0] opcode_custom3 = 7'h7b;

  // lbuf and sbuf share one funct3 and differ in funct7
  localparam logic [funct3_w-1:0] funct3_buf    = 3'd2;
  localparam logic [funct3_w-1:0] funct3_rowsum = 3'd6;

  localparam logic [funct7_w-1:0] funct7_lbuf   = 7'd1;
  localparam logic [funct7_w-1:0] funct7_sbuf   = 7'd2;
  localparam logic [funct7_w-1:0] funct7_rowsum = 7'd6;

  //////////////////////////////////////////////////
  // Decoded operation
  //////////////////////////////////////////////////

  // op_none also marks an instruction that is not recognised
  typedef enum logic [1:0] {
    op_none   = 2'd0,
    op_lbuf   = 2'd1,
    op_sbuf   = 2'd2,
    op_rowsum = 2'd3
  } nice_op_e;

endpackage

`default_nettype wire

//--- nice_mem_pkg.sv
`default_nettype none

package nice_mem_pkg;

  // Data path width of the host core
  localparam int xlen = 32;

  typedef logic [xlen-1:0] data_t;

  // Byte address on the ICB bus
  typedef logic [31:0] addr_t;

  // Address step between two consecutive row words
  localparam int unsigned word_bytes = 4;

  // ICB size code for a full 32-bit access
  localparam logic [1:0] icb_size_word = 2'd2;

endpackage

`default_nettype wire

//--- nice_buf_if.sv
`timescale 1ns/100ps
`default_nettype none

// Sequencer to row buffer link
interface nice_buf_if #(
  parameter int row_words = 3
);

  localparam int idx_w = (row_words > 1) ? $clog2(row_words) : 1;

  // Write / accumulate port
  logic                      clr_sum;
  logic                      wr_en;
  logic                      acc_en;
  logic [idx_w-1:0]          idx;
  nice_mem_pkg::data_t       wr_data;

  // Combinational read port, used by sbuf
  logic [idx_w-1:0]          rd_idx;
  nice_mem_pkg::data_t       rd_data;

  // Running row sum of accumulated words
  nice_mem_pkg::data_t       sum;

  modport seq (
    output clr_sum, wr_en, acc_en, idx, wr_data, rd_idx,
    input  rd_data, sum
  );

  // Row buffer side
  modport rbuf (
    input  clr_sum, wr_en, acc_en, idx, wr_data, rd_idx,
    output rd_data, sum
  );

endinterface

`default_nettype wire

//--- nice_xfer_if.sv
`timescale 1ns/100ps
`default_nettype none

// Sequencer to ICB master link
interface nice_xfer_if #(
  parameter int row_words = 3
);

  localparam int idx_w = (row_words > 1) ? $clog2(row_words) : 1;

  // Transfer request, valid with the start pulse
  logic                      start;
  nice_mem_pkg::addr_t       base;
  nice_isa_pkg::nice_op_e    op;

  // One pulse per accepted memory response
  logic                      beat;
  logic [idx_w-1:0]          beat_idx;
  nice_mem_pkg::data_t       beat_data;
  logic                      done;
  logic                      err;

  // Store data follows the command index
  logic [idx_w-1:0]          cmd_idx;
  nice_mem_pkg::data_t       wdata;

  modport seq (
    output start, base, op, wdata,
    input  beat, beat_idx, beat_data, cmd_idx, done, err
  );

  modport mst (
    input  start, base, op, wdata,
    output beat, beat_idx, beat_data, cmd_idx, done, err
  );

endinterface

`default_nettype wire

//--- nice_row_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module nice_row_buffer #(
  parameter int row_words = 3
) (
  input  logic       nice_clk,
  input  logic       nice_rst_n,
  nice_buf_if.rbuf   bufp
);

  nice_mem_pkg::data_t rows_q [row_words];
  nice_mem_pkg::data_t sum_q;

  //////////////////////////////////////////////////
  // Row storage
  //////////////////////////////////////////////////

  // Single port with plain write for lbuf and read-add-write for rowsum
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      for (int i = 0; i < row_words; i++) begin
        rows_q[i] <= {nice_mem_pkg::xlen{1'b0}};
      end
    end else if (bufp.wr_en) begin
      rows_q[bufp.idx] <= bufp.wr_data;
    end else if (bufp.acc_en) begin
      rows_q[bufp.idx] <= rows_q[bufp.idx] + bufp.wr_data;
    end
  end

  // Running sum of the words that came in on accumulate beats
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      sum_q <= {nice_mem_pkg::xlen{1'b0}};
    end else if (bufp.clr_sum) begin
      sum_q <= {nice_mem_pkg::xlen{1'b0}};
    end else if (bufp.acc_en) begin
      sum_q <= sum_q + bufp.wr_data;
    end
  end

  // Combinational read for store data
  assign bufp.rd_data = rows_q[bufp.rd_idx];
  assign bufp.sum     = sum_q;

  // Sequencer routes each beat to one port only
  wr_acc_excl_a: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    !(bufp.wr_en && bufp.acc_en));

endmodule

`default_nettype wire

//--- nice_icb_master.sv
`timescale 1ns/100ps
`default_nettype none

module nice_icb_master #(
  parameter int row_words = 3
) (
  input  logic                nice_clk,
  input  logic                nice_rst_n,

  output logic                nice_icb_cmd_valid,
  input  logic                nice_icb_cmd_ready,
  output nice_mem_pkg::addr_t nice_icb_cmd_addr,
  output logic                nice_icb_cmd_read,
  output nice_mem_pkg::data_t nice_icb_cmd_wdata,
  output logic [1:0]          nice_icb_cmd_size,

  input  logic                nice_icb_rsp_valid,
  output logic                nice_icb_rsp_ready,
  input  nice_mem_pkg::data_t nice_icb_rsp_rdata,
  input  logic                nice_icb_rsp_err,

  nice_xfer_if.mst            xfer
);

  localparam int idx_w = (row_words > 1) ? $clog2(row_words) : 1;
  localparam int cnt_w = $clog2(row_words + 1);
  localparam logic [idx_w-1:0] last_idx = idx_w'(row_words - 1);

  logic                   cmd_hsk;
  logic                   rsp_hsk;
  logic                   cmd_valid_q;
  logic [idx_w-1:0]       cmd_idx_q;
  nice_mem_pkg::addr_t    addr_q;
  nice_isa_pkg::nice_op_e op_q;
  logic [idx_w-1:0]       beat_cnt_q;
  logic                   err_q;
  logic [cnt_w-1:0]       out_cnt_q;

  assign cmd_hsk = nice_icb_cmd_valid & nice_icb_cmd_ready;
  assign rsp_hsk = nice_icb_rsp_valid & nice_icb_rsp_ready;

  //////////////////////////////////////////////////
  // Command side
  //////////////////////////////////////////////////

  // Next command goes out without waiting for earlier responses
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      cmd_valid_q <= 1'b0;
      cmd_idx_q   <= '0;
      addr_q      <= '0;
      op_q        <= nice_isa_pkg::op_none;
    end else if (xfer.start) begin
      cmd_valid_q <= 1'b1;
      cmd_idx_q   <= '0;
      addr_q      <= xfer.base;
      op_q        <= xfer.op;
    end else if (cmd_hsk) begin
      if (cmd_idx_q == last_idx) begin
        cmd_valid_q <= 1'b0;
      end else begin
        cmd_idx_q <= cmd_idx_q + 1'b1;
        addr_q    <= addr_q + nice_mem_pkg::addr_t'(nice_mem_pkg::word_bytes);
      end
    end
  end

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      beat_cnt_q <= '0;
      err_q      <= 1'b0;
    end else if (xfer.start) begin
      beat_cnt_q <= '0;
      err_q      <= 1'b0;
    end else if (rsp_hsk) begin
      // Error stays set for the rest of the row
      err_q      <= err_q | nice_icb_rsp_err;
      beat_cnt_q <= (beat_cnt_q == last_idx) ? '0 : beat_cnt_q + 1'b1;
    end
  end

  // Commands in flight
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      out_cnt_q <= '0;
    end else begin
      case ({cmd_hsk, rsp_hsk})
        2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
        2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
        default: out_cnt_q <= out_cnt_q;
      endcase
    end
  end

  // ICB outputs, all from registers except store data
  assign nice_icb_cmd_valid = cmd_valid_q;
  assign nice_icb_cmd_addr  = addr_q;
  assign nice_icb_cmd_read  = (op_q != nice_isa_pkg::op_sbuf);
  assign nice_icb_cmd_wdata = xfer.wdata;
  assign nice_icb_cmd_size  = nice_mem_pkg::icb_size_word;
  assign nice_icb_rsp_ready = 1'b1;

  // Beat reporting back to the sequencer
  assign xfer.cmd_idx   = cmd_idx_q;
  assign xfer.beat      = rsp_hsk;
  assign xfer.beat_idx  = beat_cnt_q;
  assign xfer.beat_data = nice_icb_rsp_rdata;
  assign xfer.done      = rsp_hsk & (beat_cnt_q == last_idx);
  assign xfer.err       = err_q | (rsp_hsk & nice_icb_rsp_err);

  // Every response must match an earlier command
  rsp_outstanding_a: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_icb_rsp_valid |-> (out_cnt_q != '0));

endmodule

`default_nettype wire

//--- nice_op_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module nice_op_sequencer #(
  parameter int row_words = 3
) (
  input  logic                nice_clk,
  input  logic                nice_rst_n,
  output logic                nice_active,
  output logic                nice_mem_holdup,

  input  logic                nice_req_valid,
  output logic                nice_req_ready,
  input  nice_mem_pkg::data_t nice_req_inst,
  input  nice_mem_pkg::data_t nice_req_rs1,

  output logic                nice_rsp_valid,
  input  logic                nice_rsp_ready,
  output nice_mem_pkg::data_t nice_rsp_rdat,
  output logic                nice_rsp_err,

  nice_xfer_if.seq            xfer,
  nice_buf_if.seq             bufp
);

  // FSM encoding
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_busy = 2'd1;
  localparam logic [1:0] st_resp = 2'd2;

  logic [1:0]                               state_q;
  logic                                     req_hsk;
  logic [nice_isa_pkg::opcode_w-1:0]        opcode;
  logic [nice_isa_pkg::funct3_w-1:0]        funct3;
  logic [nice_isa_pkg::funct7_w-1:0]        funct7;
  nice_isa_pkg::nice_op_e                   req_op;
  nice_isa_pkg::nice_op_e                   op_q;
  logic                                     rsp_err_q;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign opcode = nice_req_inst[nice_isa_pkg::opcode_lsb +: nice_isa_pkg::opcode_w];
  assign funct3 = nice_req_inst[nice_isa_pkg::funct3_lsb +: nice_isa_pkg::funct3_w];
  assign funct7 = nice_req_inst[nice_isa_pkg::funct7_lsb +: nice_isa_pkg::funct7_w];

  always_comb begin
    req_op = nice_isa_pkg::op_none;
    if (opcode == nice_isa_pkg::opcode_custom3) begin
      if (funct3 == nice_isa_pkg::funct3_buf && funct7 == nice_isa_pkg::funct7_lbuf) begin
        req_op = nice_isa_pkg::op_lbuf;
      end else if (funct3 == nice_isa_pkg::funct3_buf &&
                   funct7 == nice_isa_pkg::funct7_sbuf) begin
        req_op = nice_isa_pkg::op_sbuf;
      end else if (funct3 == nice_isa_pkg::funct3_rowsum &&
                   funct7 == nice_isa_pkg::funct7_rowsum) begin
        req_op = nice_isa_pkg::op_rowsum;
      end
    end
  end

  assign req_hsk = nice_req_valid & nice_req_ready;

  //////////////////////////////////////////////////
  // Operation FSM
  //////////////////////////////////////////////////

  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      state_q   <= st_idle;
      op_q      <= nice_isa_pkg::op_none;
      rsp_err_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (req_hsk) begin
            op_q <= req_op;
            // Unknown instruction is answered at once with an error
            if (req_op == nice_isa_pkg::op_none) begin
              state_q   <= st_resp;
              rsp_err_q <= 1'b1;
            end else begin
              state_q   <= st_busy;
              rsp_err_q <= 1'b0;
            end
          end
        end
        st_busy: begin
          // err already folds in the last beat
          if (xfer.done) begin
            state_q   <= st_resp;
            rsp_err_q <= xfer.err;
          end
        end
        st_resp: begin
          if (nice_rsp_ready) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Transfer kick-off, same cycle as acceptance
  assign xfer.start = req_hsk & (req_op != nice_isa_pkg::op_none);
  assign xfer.base  = nice_req_rs1;
  assign xfer.op    = req_op;

  // Beats land in the buffer as plain writes or accumulates
  assign bufp.clr_sum = xfer.start;
  assign bufp.wr_en   = xfer.beat & (op_q == nice_isa_pkg::op_lbuf);
  assign bufp.acc_en  = xfer.beat & (op_q == nice_isa_pkg::op_rowsum);
  assign bufp.idx     = xfer.beat_idx;
  assign bufp.wr_data = xfer.beat_data;

  // Store data read straight from the buffer
  assign bufp.rd_idx = xfer.cmd_idx;
  assign xfer.wdata  = bufp.rd_data;

  // Handshake and status outputs
  assign nice_req_ready  = (state_q == st_idle);
  assign nice_mem_holdup = (state_q == st_busy);
  assign nice_active     = (state_q != st_idle) | nice_req_valid;

  assign nice_rsp_valid = (state_q == st_resp);
  assign nice_rsp_err   = rsp_err_q;
  assign nice_rsp_rdat  = (nice_rsp_valid && op_q == nice_isa_pkg::op_rowsum) ?
                          bufp.sum : {nice_mem_pkg::xlen{1'b0}};

  // Response held until taken
  rsp_hold_a: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_rsp_valid && !nice_rsp_ready |=>
      nice_rsp_valid && $stable(nice_rsp_rdat) && $stable(nice_rsp_err));

endmodule

`default_nettype wire

//--- nice_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module nice_core_top #(
  parameter int row_words = 3
) (
  input  logic                nice_clk,
  input  logic                nice_rst_n,
  output logic                nice_active,
  output logic                nice_mem_holdup,

  // Instruction request
  input  logic                nice_req_valid,
  output logic                nice_req_ready,
  input  nice_mem_pkg::data_t nice_req_inst,
  input  nice_mem_pkg::data_t nice_req_rs1,
  input  nice_mem_pkg::data_t nice_req_rs2,

  // Instruction response
  output logic                nice_rsp_valid,
  input  logic                nice_rsp_ready,
  output nice_mem_pkg::data_t nice_rsp_rdat,
  output logic                nice_rsp_err,

  // ICB command channel
  output logic                nice_icb_cmd_valid,
  input  logic                nice_icb_cmd_ready,
  output nice_mem_pkg::addr_t nice_icb_cmd_addr,
  output logic                nice_icb_cmd_read,
  output nice_mem_pkg::data_t nice_icb_cmd_wdata,
  output logic [1:0]          nice_icb_cmd_size,

  // ICB response channel
  input  logic                nice_icb_rsp_valid,
  output logic                nice_icb_rsp_ready,
  input  nice_mem_pkg::data_t nice_icb_rsp_rdata,
  input  logic                nice_icb_rsp_err
);

  nice_buf_if  #(.row_words(row_words)) buf_link ();
  nice_xfer_if #(.row_words(row_words)) xfer_link ();

  // Decode, FSM and response
  nice_op_sequencer #(.row_words(row_words)) i_seq (
    .nice_clk        (nice_clk),
    .nice_rst_n      (nice_rst_n),
    .nice_active     (nice_active),
    .nice_mem_holdup (nice_mem_holdup),
    .nice_req_valid  (nice_req_valid),
    .nice_req_ready  (nice_req_ready),
    .nice_req_inst   (nice_req_inst),
    .nice_req_rs1    (nice_req_rs1),
    .nice_rsp_valid  (nice_rsp_valid),
    .nice_rsp_ready  (nice_rsp_ready),
    .nice_rsp_rdat   (nice_rsp_rdat),
    .nice_rsp_err    (nice_rsp_err),
    .xfer            (xfer_link.seq),
    .bufp            (buf_link.seq)
  );

  // Memory side
  nice_icb_master #(.row_words(row_words)) i_icb (
    .nice_clk           (nice_clk),
    .nice_rst_n         (nice_rst_n),
    .nice_icb_cmd_valid (nice_icb_cmd_valid),
    .nice_icb_cmd_ready (nice_icb_cmd_ready),
    .nice_icb_cmd_addr  (nice_icb_cmd_addr),
    .nice_icb_cmd_read  (nice_icb_cmd_read),
    .nice_icb_cmd_wdata (nice_icb_cmd_wdata),
    .nice_icb_cmd_size  (nice_icb_cmd_size),
    .nice_icb_rsp_valid (nice_icb_rsp_valid),
    .nice_icb_rsp_ready (nice_icb_rsp_ready),
    .nice_icb_rsp_rdata (nice_icb_rsp_rdata),
    .nice_icb_rsp_err   (nice_icb_rsp_err),
    .xfer               (xfer_link.mst)
  );

  // Row storage
  nice_row_buffer #(.row_words(row_words)) i_rowbuf (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .bufp       (buf_link.rbuf)
  );

endmodule

`default_nettype wire

//--- tb_nice_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_nice_core_top;

  localparam int row_words = 3;
  localparam int mem_words = 64;
  // Byte addresses in [err_lo, err_hi) answer with a bus error
  localparam logic [31:0] err_lo = 32'h80;
  localparam logic [31:0] err_hi = 32'h90;

  // One table row
  typedef struct {
    nice_isa_pkg::nice_op_e op;
    logic [31:0]            raw;
    logic [31:0]            rs1;
    bit                     hold;
    bit                     exp_err;
  } step_t;

  logic                nice_clk;
  logic                nice_rst_n;
  logic                nice_active;
  logic                nice_mem_holdup;
  logic                nice_req_valid;
  logic                nice_req_ready;
  nice_mem_pkg::data_t nice_req_inst;
  nice_mem_pkg::data_t nice_req_rs1;
  nice_mem_pkg::data_t nice_req_rs2;
  logic                nice_rsp_valid;
  logic                nice_rsp_ready;
  nice_mem_pkg::data_t nice_rsp_rdat;
  logic                nice_rsp_err;
  logic                nice_icb_cmd_valid;
  logic                nice_icb_cmd_ready;
  nice_mem_pkg::addr_t nice_icb_cmd_addr;
  logic                nice_icb_cmd_read;
  nice_mem_pkg::data_t nice_icb_cmd_wdata;
  logic [1:0]          nice_icb_cmd_size;
  logic                nice_icb_rsp_valid;
  logic                nice_icb_rsp_ready;
  nice_mem_pkg::data_t nice_icb_rsp_rdata;
  logic                nice_icb_rsp_err;

  // Memory model and reference model state
  logic [31:0] mem [mem_words];
  logic [31:0] ref_mem [mem_words];
  logic [31:0] ref_buf [row_words];
  logic [31:0] rsp_data_q [$];
  logic        rsp_err_q [$];
  int          rsp_due_q [$];
  int          cycle_cnt;
  int          last_due;
  step_t       steps [$];

  // Instruction in flight as the memory model expects it
  logic [31:0] exp_base;
  logic        exp_read;
  int          exp_cmds;
  int          cmd_cnt;

  nice_core_top #(.row_words(row_words)) i_dut (
    .nice_clk           (nice_clk),
    .nice_rst_n         (nice_rst_n),
    .nice_active        (nice_active),
    .nice_mem_holdup    (nice_mem_holdup),
    .nice_req_valid     (nice_req_valid),
    .nice_req_ready     (nice_req_ready),
    .nice_req_inst      (nice_req_inst),
    .nice_req_rs1       (nice_req_rs1),
    .nice_req_rs2       (nice_req_rs2),
    .nice_rsp_valid     (nice_rsp_valid),
    .nice_rsp_ready     (nice_rsp_ready),
    .nice_rsp_rdat      (nice_rsp_rdat),
    .nice_rsp_err       (nice_rsp_err),
    .nice_icb_cmd_valid (nice_icb_cmd_valid),
    .nice_icb_cmd_ready (nice_icb_cmd_ready),
    .nice_icb_cmd_addr  (nice_icb_cmd_addr),
    .nice_icb_cmd_read  (nice_icb_cmd_read),
    .nice_icb_cmd_wdata (nice_icb_cmd_wdata),
    .nice_icb_cmd_size  (nice_icb_cmd_size),
    .nice_icb_rsp_valid (nice_icb_rsp_valid),
    .nice_icb_rsp_ready (nice_icb_rsp_ready),
    .nice_icb_rsp_rdata (nice_icb_rsp_rdata),
    .nice_icb_rsp_err   (nice_icb_rsp_err)
  );

  always #50 nice_clk = ~nice_clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  // Fill pattern spread over every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  // R-type word with rd = x3, rs1 = x2, rs2 = x1
  function automatic logic [31:0] encode_inst(input nice_isa_pkg::nice_op_e op);
    logic [6:0] f7;
    logic [2:0] f3;
    f3 = nice_isa_pkg::funct3_buf;
    f7 = nice_isa_pkg::funct7_lbuf;
    if (op == nice_isa_pkg::op_sbuf) begin
      f7 = nice_isa_pkg::funct7_sbuf;
    end else if (op == nice_isa_pkg::op_rowsum) begin
      f3 = nice_isa_pkg::funct3_rowsum;
      f7 = nice_isa_pkg::funct7_rowsum;
    end
    return {f7, 5'd1, 5'd2, f3, 5'd3, nice_isa_pkg::opcode_custom3};
  endfunction

  task automatic add_step(input nice_isa_pkg::nice_op_e op, input logic [31:0] raw,
                          input logic [31:0] rs1, input bit hold, input bit exp_err);
    step_t s;
    s.op      = op;
    s.raw     = raw;
    s.rs1     = rs1;
    s.hold    = hold;
    s.exp_err = exp_err;
    steps.push_back(s);
  endtask

  // Reference row buffer and memory stepped one instruction at a time
  task automatic model_step(input step_t s, output logic [31:0] rdat);
    int w;
    rdat = '0;
    for (int i = 0; i < row_words; i++) begin
      w = int'(s.rs1 >> 2) + i;
      case (s.op)
        nice_isa_pkg::op_lbuf: ref_buf[i] = ref_mem[w];
        nice_isa_pkg::op_sbuf: ref_mem[w] = ref_buf[i];
        nice_isa_pkg::op_rowsum: begin
          rdat       = rdat + ref_mem[w];
          ref_buf[i] = ref_buf[i] + ref_mem[w];
        end
        default: rdat = '0;
      endcase
    end
  endtask

  //////////////////////////////////////////////////
  // ICB memory model
  //////////////////////////////////////////////////

  initial begin : memory_model
    logic        take;
    logic [31:0] addr;
    int          due;
    nice_icb_cmd_ready = 1'b0;
    nice_icb_rsp_valid = 1'b0;
    nice_icb_rsp_rdata = '0;
    nice_icb_rsp_err   = 1'b0;
    void'($urandom(32'h2a6d));
    forever begin
      @(negedge nice_clk);
      cycle_cnt++;
      // Command accepted on the coming rising edge
      take = nice_rst_n && ($urandom % 4 != 0);
      addr = nice_icb_cmd_addr;
      if (nice_icb_cmd_valid && take) begin
        assert (cmd_cnt < exp_cmds) else abort_run("ICB command that was not expected");
        check_value("nice_icb_cmd_addr", addr, exp_base + 32'(4 * cmd_cnt));
        check_value("nice_icb_cmd_read", nice_icb_cmd_read, exp_read);
        check_value("nice_icb_cmd_size", nice_icb_cmd_size, nice_mem_pkg::icb_size_word);
        assert (addr < mem_words * 4) else abort_run("ICB address outside the memory");
        if (!nice_icb_cmd_read) begin
          mem[addr[7:2]] = nice_icb_cmd_wdata;
        end
        // Random latency with responses kept in command order
        due = cycle_cnt + 1 + int'($urandom % 4);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_data_q.push_back(nice_icb_cmd_read ? mem[addr[7:2]] : 32'h0);
        rsp_err_q.push_back(addr >= err_lo && addr < err_hi);
        rsp_due_q.push_back(due);
        cmd_cnt++;
      end
      // Response side
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle_cnt) begin
        assert (nice_icb_rsp_ready === 1'b1) else abort_run("ICB response ready was low");
        nice_icb_rsp_valid = 1'b1;
        nice_icb_rsp_rdata = rsp_data_q.pop_front();
        nice_icb_rsp_err   = rsp_err_q.pop_front();
        void'(rsp_due_q.pop_front());
      end else begin
        nice_icb_rsp_valid = 1'b0;
        nice_icb_rsp_rdata = '0;
        nice_icb_rsp_err   = 1'b0;
      end
      nice_icb_cmd_ready = take;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////

  initial begin : stimulus
    step_t       s;
    logic [31:0] exp_rdat;
    logic [31:0] got_rdat;
    logic        got_err;
    int          n;
    nice_clk       = 1'b0;
    nice_rst_n     = 1'b0;
    nice_req_valid = 1'b0;
    nice_req_inst  = '0;
    nice_req_rs1   = '0;
    nice_req_rs2   = '0;
    nice_rsp_ready = 1'b0;
    exp_cmds       = 0;
    cmd_cnt        = 0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i]     = fill_word(32'(i * 4));
      ref_mem[i] = mem[i];
    end
    for (int i = 0; i < row_words; i++) begin
      ref_buf[i] = '0;
    end
    // op, raw word for op_none, rs1, hold rsp_ready low, expected err
    add_step(nice_isa_pkg::op_lbuf,   32'h0,         32'h10, 0, 0);
    add_step(nice_isa_pkg::op_sbuf,   32'h0,         32'h40, 1, 0);
    add_step(nice_isa_pkg::op_rowsum, 32'h0,         32'h20, 0, 0);
    add_step(nice_isa_pkg::op_sbuf,   32'h0,         32'h50, 0, 0);
    add_step(nice_isa_pkg::op_rowsum, 32'h0,         32'h7c, 1, 1);
    add_step(nice_isa_pkg::op_lbuf,   32'h0,         32'h88, 0, 1);
    add_step(nice_isa_pkg::op_sbuf,   32'h0,         32'h90, 0, 0);
    add_step(nice_isa_pkg::op_none,   32'h0000_707b, 32'h30, 1, 1);
    add_step(nice_isa_pkg::op_none,   32'h0c00_6033, 32'h30, 0, 1);
    add_step(nice_isa_pkg::op_lbuf,   32'h0,         32'h00, 0, 0);

    repeat (8) @(posedge nice_clk);
    @(negedge nice_clk);
    nice_rst_n = 1'b1;
    @(negedge nice_clk);
    // Idle state out of reset
    check_value("nice_req_ready", nice_req_ready, 1'b1);
    check_value("nice_rsp_valid", nice_rsp_valid, 1'b0);
    check_value("nice_icb_cmd_valid", nice_icb_cmd_valid, 1'b0);
    check_value("nice_mem_holdup", nice_mem_holdup, 1'b0);
    check_value("nice_active", nice_active, 1'b0);

    foreach (steps[k]) begin
      s = steps[k];
      model_step(s, exp_rdat);
      exp_base = s.rs1;
      exp_read = (s.op != nice_isa_pkg::op_sbuf);
      exp_cmds = (s.op == nice_isa_pkg::op_none) ? 0 : row_words;
      cmd_cnt  = 0;
      n = 0;
      while (!nice_req_ready) begin
        @(negedge nice_clk);
        n++;
        assert (n < 50) else abort_run("Timeout waiting for nice_req_ready");
      end
      nice_req_valid = 1'b1;
      nice_req_inst  = (s.op == nice_isa_pkg::op_none) ? s.raw : encode_inst(s.op);
      nice_req_rs1   = s.rs1;
      nice_rsp_ready = !s.hold;
      @(negedge nice_clk);
      nice_req_valid = 1'b0;
      // Holdup only for real memory work
      check_value("nice_mem_holdup", nice_mem_holdup, s.op != nice_isa_pkg::op_none);
      check_value("nice_active", nice_active, 1'b1);
      n = 0;
      while (!nice_rsp_valid) begin
        @(negedge nice_clk);
        n++;
        assert (n < 200) else abort_run("Timeout waiting for nice_rsp_valid");
      end
      got_rdat = nice_rsp_rdat;
      got_err  = nice_rsp_err;
      if (s.hold) begin
        // Response frozen while the host stalls
        repeat (4) begin
          @(negedge nice_clk);
          check_value("nice_rsp_valid", nice_rsp_valid, 1'b1);
          check_value("nice_rsp_rdat", nice_rsp_rdat, got_rdat);
          check_value("nice_rsp_err", nice_rsp_err, got_err);
          check_value("nice_req_ready", nice_req_ready, 1'b0);
          check_value("nice_active", nice_active, 1'b1);
        end
        nice_rsp_ready = 1'b1;
      end
      check_value("nice_rsp_rdat", got_rdat, exp_rdat);
      check_value("nice_rsp_err", got_err, s.exp_err);
      check_value("icb_cmd_count", cmd_cnt, exp_cmds);
      @(negedge nice_clk);
      nice_rsp_ready = 1'b0;
      check_value("nice_rsp_valid", nice_rsp_valid, 1'b0);
      // Back in idle with no request pending
      check_value("nice_active", nice_active, 1'b0);
      // Whole memory against the reference
      for (int i = 0; i < mem_words; i++) begin
        check_value($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
nice_isa_pkg.sv
nice_mem_pkg.sv
nice_buf_if.sv
nice_xfer_if.sv
nice_row_buffer.sv
nice_icb_master.sv
nice_op_sequencer.sv
nice_core_top.sv
tb_nice_core_top.sv

//--- Bender.yml
package:
  name: nice_core

sources:
  - nice_isa_pkg.sv
  - nice_mem_pkg.sv
  - nice_buf_if.sv
  - nice_xfer_if.sv
  - nice_row_buffer.sv
  - nice_icb_master.sv
  - nice_op_sequencer.sv
  - nice_core_top.sv
  - target: test
    files:
      - tb_nice_core_top.sv
